// ==== sensor_bt_link.f ====
src/bt_link_pkg.sv
src/bt_fsm_pkg.sv
src/stream_fifo.sv
src/stream_selector.sv
src/uart_tx.sv
src/link_controller.sv
src/sensor_bt_link.sv
test/tb_sensor_bt_link.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and scan the log for a failure
set -e

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing \
	-f sensor_bt_link.f \
	--top-module tb_sensor_bt_link \
	-Mdir obj_dir \
	-o sim_tb

# The simulator exits non-zero on $fatal, so the log decides the result
./obj_dir/sim_tb 2>&1 | tee "$LOG"

if grep -q "TEST FAILED" "$LOG"; then
	echo "Simulation failed, see $LOG"
	exit 1
fi

echo "Simulation finished, see $LOG"

// ==== test/tb_sensor_bt_link.sv ====
/*
	Testbench for the sensor stream to UART link: random stimulus,
	round-robin reference model, serial line checks and compare tasks
*/

`timescale 1ns/1ns
`default_nettype none

module tb_sensor_bt_link
	import bt_link_pkg::*;
();

	localparam int FIFO_DEPTH = 8;
	localparam int NUM_ROUNDS = 6;
	localparam int START_TIMEOUT = 2000;
	localparam int BUSY_TIMEOUT = 2000;

	logic clock;
	logic reset;
	stream_mask_t stream_write;
	stream_word_t stream_data [NUM_STREAMS];
	stream_mask_t stream_full;
	stream_mask_t stream_mask;
	logic link_enable;
	baud_count_t bit_period;
	baud_count_t gap_cycles;
	logic txd;
	logic busy;

	integer seed;

	// Reference model state
	stream_word_t chan_q [NUM_STREAMS][$];
	stream_word_t exp_words [$];
	stream_idx_t last_idx;

	sensor_bt_link #(
		.FIFO_DEPTH(FIFO_DEPTH)
	) u_sensor_bt_link (
		.clock(clock),
		.reset(reset),
		.stream_write(stream_write),
		.stream_data(stream_data),
		.stream_full(stream_full),
		.stream_mask(stream_mask),
		.link_enable(link_enable),
		.bit_period(bit_period),
		.gap_cycles(gap_cycles),
		.txd(txd),
		.busy(busy)
	);

	initial
		clock = 1'b0;

	always #10 clock = ~clock;

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("TEST FAILED");
		$fatal(1);
	endtask

	task automatic check_bit(input string name, input logic actual, input logic expected);
		if (actual !== expected)
			fail_run($sformatf("** Error: %s = 0x%0h, expected 0x%0h", name, actual, expected));
	endtask

	task automatic check_byte(input string name, input uart_byte_t actual,
		input uart_byte_t expected);
		if (actual !== expected)
			fail_run($sformatf("** Error: %s = 0x%02h, expected 0x%02h", name, actual, expected));
	endtask

	task automatic check_word(input string name, input stream_word_t actual,
		input stream_word_t expected);
		if (actual !== expected)
			fail_run($sformatf("** Error: %s = 0x%04h, expected 0x%04h", name, actual, expected));
	endtask

	task automatic check_mask(input string name, input stream_mask_t actual,
		input stream_mask_t expected);
		if (actual !== expected)
			fail_run($sformatf("** Error: %s = 0x%02h, expected 0x%02h", name, actual, expected));
	endtask

	// A channel is full once the model holds FIFO_DEPTH words
	function automatic stream_mask_t model_full();
		stream_mask_t m;
		for (int ch = 0; ch < NUM_STREAMS; ch++)
			m[ch] = (chan_q[ch].size() == FIFO_DEPTH);
		return m;
	endfunction

	// Round-robin from the channel after the last served one
	task automatic build_expected();
		stream_idx_t cand;
		logic found;
		do
		begin
			found = 1'b0;
			for (int k = 1; k <= NUM_STREAMS && !found; k++)
			begin
				cand = stream_idx_t'((int'(last_idx) + k) % NUM_STREAMS);
				if (stream_mask[cand] && chan_q[cand].size() > 0)
				begin
					found = 1'b1;
					exp_words.push_back(chan_q[cand].pop_front());
					last_idx = cand;
				end
			end
		end while (found);
	endtask

	// Random writes, then a burst that overflows one channel
	task automatic load_streams();
		int n_cycles;
		stream_idx_t burst_ch;
		n_cycles = 4 + $unsigned($random(seed)) % 9;
		burst_ch = stream_idx_t'($random(seed));
		for (int cyc = 0; cyc < n_cycles + FIFO_DEPTH + 2; cyc++)
		begin
			@(negedge clock);
			if (cyc < n_cycles)
				stream_write = stream_mask_t'($random(seed));
			else
				stream_write = stream_mask_t'(1) << burst_ch;
			for (int ch = 0; ch < NUM_STREAMS; ch++)
			begin
				stream_data[ch] = stream_word_t'($random(seed));
				if (stream_write[ch] && chan_q[ch].size() < FIFO_DEPTH)
					chan_q[ch].push_back(stream_data[ch]);
			end
		end
		@(negedge clock);
		stream_write = '0;
	endtask

	// Whole bit must hold one level, so the mid-bit sample equals the first
	task automatic sample_bit(output logic level);
		level = txd;
		for (int c = 1; c < int'(bit_period); c++)
		begin
			@(negedge clock);
			if (txd !== level)
				fail_run("txd changed level within one bit period");
		end
	endtask

	task automatic receive_byte(output uart_byte_t value, input logic check_gap);
		int high_cycles;
		logic level;
		high_cycles = 0;
		@(negedge clock);
		while (txd !== 1'b0)
		begin
			high_cycles++;
			if (high_cycles >= START_TIMEOUT)
				fail_run("Timeout waiting for a start bit on txd");
			@(negedge clock);
		end
		if (check_gap && high_cycles < int'(gap_cycles))
			fail_run($sformatf("txd idle for %0d cycles between frames, gap_cycles is %0d",
				high_cycles, gap_cycles));
		sample_bit(level);
		for (int b = 0; b < 8; b++)
		begin
			@(negedge clock);
			sample_bit(level);
			value[b] = level;
		end
		@(negedge clock);
		sample_bit(level);
		check_bit("txd stop bit", level, 1'b1);
	endtask

	// No frame may start while the link winds down
	task automatic wait_idle();
		int waited;
		waited = 0;
		@(negedge clock);
		while (busy !== 1'b0)
		begin
			if (txd !== 1'b1)
				fail_run("Unexpected frame on txd after the last expected word");
			waited++;
			if (waited >= BUSY_TIMEOUT)
				fail_run("Timeout waiting for busy to fall");
			@(negedge clock);
		end
	endtask

	initial
	begin
		uart_byte_t lo_byte;
		uart_byte_t hi_byte;
		stream_word_t word;
		logic first_frame;
		seed = 32'h89894c6b;
		last_idx = 3'd7;
		reset = 1'b1;
		stream_write = '0;
		for (int ch = 0; ch < NUM_STREAMS; ch++)
			stream_data[ch] = '0;
		stream_mask = '0;
		link_enable = 1'b0;
		bit_period = baud_count_t'(4);
		gap_cycles = baud_count_t'(1);
		repeat (10) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;
		@(negedge clock);
		check_bit("txd", txd, 1'b1);
		check_bit("busy", busy, 1'b0);
		check_mask("stream_full", stream_full, '0);

		for (int round = 0; round < NUM_ROUNDS; round++)
		begin
			@(negedge clock);
			link_enable = 1'b0;
			// Last round opens every channel so nothing stays behind
			if (round == NUM_ROUNDS - 1)
				stream_mask = '1;
			else
				stream_mask = stream_mask_t'($random(seed));
			bit_period = baud_count_t'(4 + $unsigned($random(seed)) % 9);
			gap_cycles = baud_count_t'(1 + $unsigned($random(seed)) % 16);
			load_streams();
			check_mask("stream_full", stream_full, model_full());
			build_expected();
			link_enable = 1'b1;
			first_frame = 1'b1;
			while (exp_words.size() > 0)
			begin
				word = exp_words.pop_front();
				receive_byte(lo_byte, !first_frame);
				check_byte("txd low byte", lo_byte, word[7:0]);
				receive_byte(hi_byte, 1'b1);
				check_word("txd word", {hi_byte, lo_byte}, word);
				first_frame = 1'b0;
			end
			wait_idle();
			check_mask("stream_full", stream_full, model_full());
		end

		$display("TEST PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== src/sensor_bt_link.sv ====
/*
	Top level: eight stream FIFOs, round-robin selector,
	link controller and UART transmitter
*/

`timescale 1ns/1ns
`default_nettype none

module sensor_bt_link
	import bt_link_pkg::*;
#(
	parameter int FIFO_DEPTH = 16
)
(
	input wire clock,
	input wire reset,
	input wire stream_mask_t stream_write,
	input wire stream_word_t stream_data [NUM_STREAMS],
	output stream_mask_t stream_full,
	input wire stream_mask_t stream_mask,
	input wire link_enable,
	input wire baud_count_t bit_period,
	input wire baud_count_t gap_cycles,
	output logic txd,
	output logic busy
);

	stream_mask_t fifo_empty;
	stream_mask_t fifo_pop;
	stream_word_t fifo_words [NUM_STREAMS];
	stream_word_t selected_word;
	uart_byte_t tx_byte;
	logic select_request;
	logic select_ready;
	logic any_ready;
	logic tx_start;
	logic tx_done;

	// One FIFO per sensor stream
	for (genvar i = 0; i < NUM_STREAMS; i++)
	begin : g_stream
		stream_fifo #(
			.FIFO_DEPTH(FIFO_DEPTH)
		) u_stream_fifo (
			.clock(clock),
			.reset(reset),
			.write(stream_write[i]),
			.wr_data(stream_data[i]),
			.pop(fifo_pop[i]),
			.rd_data(fifo_words[i]),
			.full(stream_full[i]),
			.empty(fifo_empty[i])
		);
	end

	stream_selector u_stream_selector (
		.clock(clock),
		.reset(reset),
		.stream_mask(stream_mask),
		.empty_flags(fifo_empty),
		.fifo_words(fifo_words),
		.select_request(select_request),
		.select_ready(select_ready),
		.selected_word(selected_word),
		.pop(fifo_pop),
		.any_ready(any_ready)
	);

	link_controller u_link_controller (
		.clock(clock),
		.reset(reset),
		.link_enable(link_enable),
		.gap_cycles(gap_cycles),
		.any_ready(any_ready),
		.select_request(select_request),
		.select_ready(select_ready),
		.selected_word(selected_word),
		.tx_start(tx_start),
		.tx_byte(tx_byte),
		.tx_done(tx_done),
		.busy(busy)
	);

	uart_tx u_uart_tx (
		.clock(clock),
		.reset(reset),
		.tx_start(tx_start),
		.tx_byte(tx_byte),
		.bit_period(bit_period),
		.txd(txd),
		.tx_done(tx_done)
	);

endmodule

`default_nettype wire

// ==== src/link_controller.sv ====
/*
	Link control FSM: word latch, byte-half tracking and inter-byte gap timer
*/

`timescale 1ns/1ns
`default_nettype none

module link_controller
	import bt_link_pkg::*;
	import bt_fsm_pkg::*;
(
	input wire clock,
	input wire reset,
	input wire link_enable,
	input wire baud_count_t gap_cycles,
	input wire any_ready,
	output logic select_request,
	input wire select_ready,
	input wire stream_word_t selected_word,
	output logic tx_start,
	output uart_byte_t tx_byte,
	input wire tx_done,
	output logic busy
);

	link_state_t state;
	link_state_t state_next;
	stream_word_t word_latch;
	baud_count_t gap_count;
	logic high_half;
	logic requested;
	logic gap_done;
	logic launch_low;
	logic launch_high;

	// Gap of at least one cycle even when gap_cycles is zero
	assign gap_done = (gap_count >= gap_cycles);

	assign launch_low = (state == st_pop);
	assign launch_high = (state == st_gap) && gap_done && !high_half;

	// One request pulse per visit to st_wait_select
	assign select_request = (state == st_wait_select) && !requested;
	assign busy = (state != st_idle);

	always_comb
	begin
		state_next = state;
		case (state)
			st_idle:
				if (link_enable && any_ready)
					state_next = st_wait_select;
			st_wait_select:
				if (select_ready)
					state_next = st_pop;
				else if (requested)
					state_next = st_idle;
			st_pop:
				state_next = st_send;
			st_send:
				if (tx_done)
					state_next = st_gap;
			st_gap:
				if (gap_done)
				begin
					if (!high_half)
						state_next = st_send;
					else if (link_enable && any_ready)
						state_next = st_wait_select;
					else
						state_next = st_idle;
				end
			default:
				state_next = st_idle;
		endcase
	end

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			state <= st_idle;
			requested <= 1'b0;
			high_half <= 1'b0;
			gap_count <= '0;
			tx_start <= 1'b0;
		end
		else
		begin
			state <= state_next;
			requested <= select_request;
			tx_start <= launch_low || launch_high;
			if (launch_low)
				high_half <= 1'b0;
			else if (launch_high)
				high_half <= 1'b1;
			if (tx_done)
				gap_count <= baud_count_t'(1);
			else if (state == st_gap)
				gap_count <= gap_count + 1'b1;
		end
	end

	// Popped word, then the byte handed to the UART
	always_ff @(posedge clock)
	begin
		if (state == st_wait_select && select_ready)
			word_latch <= selected_word;
		if (launch_low)
			tx_byte <= word_latch[7:0];
		else if (launch_high)
			tx_byte <= word_latch[15:8];
	end

endmodule

`default_nettype wire

// ==== src/uart_tx.sv ====
/*
	8N1 UART transmitter, bit period set at run time
*/

`timescale 1ns/1ns
`default_nettype none

module uart_tx
	import bt_link_pkg::*;
	import bt_fsm_pkg::*;
(
	input wire clock,
	input wire reset,
	input wire tx_start,
	input wire uart_byte_t tx_byte,
	input wire baud_count_t bit_period,
	output logic txd,
	output logic tx_done
);

	uart_state_t state;
	baud_count_t bit_count;
	logic [2:0] bit_index;
	uart_byte_t shift_reg;
	logic bit_end;

	// Last cycle of the current bit
	assign bit_end = (bit_count == bit_period - baud_count_t'(1));

	// The start-bit state shares its name with the start port
	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			state <= tx_idle;
			bit_count <= '0;
			bit_index <= '0;
		end
		else
		begin
			case (state)
				tx_idle:
				begin
					bit_count <= '0;
					bit_index <= '0;
					if (tx_start)
						state <= bt_fsm_pkg::tx_start;
				end
				bt_fsm_pkg::tx_start:
				begin
					bit_count <= bit_end ? '0 : bit_count + 1'b1;
					if (bit_end)
						state <= tx_data;
				end
				tx_data:
				begin
					bit_count <= bit_end ? '0 : bit_count + 1'b1;
					if (bit_end)
					begin
						if (bit_index == 3'd7)
							state <= tx_stop;
						else
							bit_index <= bit_index + 1'b1;
					end
				end
				tx_stop:
				begin
					bit_count <= bit_end ? '0 : bit_count + 1'b1;
					if (bit_end)
						state <= tx_idle;
				end
				default: state <= tx_idle;
			endcase
		end
	end

	// LSB first, shifted out at each data bit boundary
	always_ff @(posedge clock)
	begin
		if (state == tx_idle && tx_start)
			shift_reg <= tx_byte;
		else if (state == tx_data && bit_end)
			shift_reg <= shift_reg >> 1;
	end

	always_comb
	begin
		case (state)
			bt_fsm_pkg::tx_start: txd = 1'b0;
			tx_data: txd = shift_reg[0];
			default: txd = 1'b1;
		endcase
	end

	assign tx_done = (state == tx_stop) && bit_end;

endmodule

`default_nettype wire

// ==== src/stream_selector.sv ====
/*
	Round-robin channel selector with word mux and FIFO pop strobes
*/

`timescale 1ns/1ns
`default_nettype none

module stream_selector
	import bt_link_pkg::*;
(
	input wire clock,
	input wire reset,
	input wire stream_mask_t stream_mask,
	input wire stream_mask_t empty_flags,
	input wire stream_word_t fifo_words [NUM_STREAMS],
	input wire select_request,
	output logic select_ready,
	output stream_word_t selected_word,
	output stream_mask_t pop,
	output logic any_ready
);

	stream_mask_t ready_flags;
	stream_idx_t last_idx;
	stream_idx_t sel_idx;
	stream_idx_t next_idx;
	stream_idx_t cand_idx;
	logic next_found;

	// Enabled and holding data
	assign ready_flags = stream_mask & ~empty_flags;
	assign any_ready = |ready_flags;

	// Search starts just past the last served channel
	always_comb
	begin
		next_found = 1'b0;
		next_idx = last_idx;
		cand_idx = last_idx;
		for (int k = 1; k <= NUM_STREAMS; k++)
		begin
			cand_idx = stream_idx_t'(last_idx + k);
			if (!next_found && ready_flags[cand_idx])
			begin
				next_found = 1'b1;
				next_idx = cand_idx;
			end
		end
	end

	always_ff @(posedge clock)
	begin
		if (select_request)
			sel_idx <= next_idx;
	end

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			select_ready <= 1'b0;
			last_idx <= 3'd7;
		end
		else
		begin
			select_ready <= select_request && next_found;
			if (select_ready)
				last_idx <= sel_idx;
		end
	end

	// Word and pop go out together in the ready cycle
	assign selected_word = fifo_words[sel_idx];
	assign pop = select_ready ? (stream_mask_t'(1) << sel_idx) : '0;

endmodule

`default_nettype wire

// ==== src/stream_fifo.sv ====
/*
	First-word-fall-through FIFO for one sensor stream
*/

`timescale 1ns/1ns
`default_nettype none

module stream_fifo
	import bt_link_pkg::*;
#(
	parameter int FIFO_DEPTH = 16
)
(
	input wire clock,
	input wire reset,
	input wire write,
	input wire stream_word_t wr_data,
	input wire pop,
	output stream_word_t rd_data,
	output logic full,
	output logic empty
);

	localparam int ADDR_W = $clog2(FIFO_DEPTH);

	stream_word_t mem [FIFO_DEPTH];
	logic [ADDR_W-1:0] wr_ptr;
	logic [ADDR_W-1:0] rd_ptr;
	logic [ADDR_W:0] count;
	logic do_write;
	logic do_read;

	// Writes into a full buffer are dropped here
	assign do_write = write && !full;
	assign do_read = pop && !empty;

	assign full = (count == (ADDR_W+1)'(FIFO_DEPTH));
	assign empty = (count == '0);

	// Head word always on the output
	assign rd_data = mem[rd_ptr];

	always_ff @(posedge clock)
	begin
		if (do_write)
			mem[wr_ptr] <= wr_data;
	end

	// Pointers wrap naturally since the depth is a power of two
	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end
		else
		begin
			if (do_write)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_read)
				rd_ptr <= rd_ptr + 1'b1;
			case ({do_write, do_read})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== src/bt_fsm_pkg.sv ====
/*
	State encodings for the link controller and the UART transmitter
*/

`default_nettype none

package bt_fsm_pkg;

	// Link controller, one word per pass
	typedef enum logic [2:0] {
		st_idle,
		st_wait_select,
		st_pop,
		st_send,
		st_gap
	} link_state_t;

	// 8N1 transmitter
	typedef enum logic [1:0] {
		tx_idle,
		tx_start,
		tx_data,
		tx_stop
	} uart_state_t;

endpackage

`default_nettype wire

// ==== src/bt_link_pkg.sv ====
/*
	Data and width types for the sensor stream to UART link,
	plus the number of sensor streams
*/

`default_nettype none

package bt_link_pkg;

	// Number of sensor datastreams feeding the link
	localparam int NUM_STREAMS = 8;

	// One sample word from a sensor stream
	typedef logic [15:0] stream_word_t;

	// One serial character on the UART
	typedef logic [7:0] uart_byte_t;

	// Channel number
	typedef logic [2:0] stream_idx_t;

	// One bit per channel, used for strobes, flags and the enable mask
	typedef logic [NUM_STREAMS-1:0] stream_mask_t;

	// Cycle count for bit period and inter-byte gap
	typedef logic [9:0] baud_count_t;

endpackage

`default_nettype wire
